/* verilog/rr_pkg.sv */
`default_nettype none

package rr_pkg;

   // Datapath widths
   localparam int DW      = 64;             // Operand and immediate
   localparam int PC_W    = 32;
   localparam int ROB_AW  = 5;              // ROB entry id

   // Physical register file geometry
   localparam int PRF_AW  = 6;
   localparam int PRF_NUM = 1 << PRF_AW;    // 64 entries

   // Micro-op control fields
   localparam int OPC_W   = 8;
   localparam int FU_W    = 5;              // One bit per functional unit

   // Operand, immediate and PRF read data
   typedef logic [DW-1:0]     data_t;

   typedef logic [PC_W-1:0]   pc_t;

   // Physical register index
   typedef logic [PRF_AW-1:0] preg_t;

   typedef logic [ROB_AW-1:0] rob_id_t;

   typedef logic [OPC_W-1:0]  opc_t;

   // One-hot unit select
   // ALU, BRU, LSU, EPU, LPU from bit 0 upward
   typedef logic [FU_W-1:0]   fu_sel_t;

endpackage

`default_nettype wire

/* verilog/prf_rd_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface prf_rd_if
   import rr_pkg::*;
();

   // Read requests, valid for one edge each
   logic  re1;
   preg_t raddr1;
   logic  re2;
   preg_t raddr2;

   // Registered read data, held until the next enabled read
   data_t rdata1;
   data_t rdata2;

   modport stage (
      output re1, raddr1, re2, raddr2,
      input  rdata1, rdata2
   );

   modport rf (
      input  re1, raddr1, re2, raddr2,
      output rdata1, rdata2
   );

endinterface

`default_nettype wire

/* verilog/hds_buf.sv */
`timescale 1ns/1ps
`default_nettype none

// Single-entry valid/ready slot
// p_ce loads the data registers kept in the neighbouring modules
module hds_buf
(
   input  logic clk,
   input  logic rst_n,
   input  logic flush,
   // Producer side
   input  logic a_valid,
   output logic a_ready,
   // Consumer side
   output logic b_valid,
   input  logic b_ready,
   // Pipeline enable
   output logic p_ce
);

   logic valid_q;

   // Room when the slot is empty or being drained this cycle
   assign a_ready = ~flush & (~valid_q | b_ready);

   assign p_ce    = a_valid & a_ready;   // Accepting handshake

   assign b_valid = valid_q;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         valid_q <= 1'b0;
      end
      else if (flush)
      begin
         valid_q <= 1'b0;                 // Kill the held micro-op
      end
      else if (p_ce)
      begin
         valid_q <= 1'b1;                 // New entry, possibly replacing one taken
      end
      else if (b_ready)
      begin
         valid_q <= 1'b0;                 // Drained with nothing behind it
      end
   end

endmodule

`default_nettype wire

/* verilog/prf.sv */
`timescale 1ns/1ps
`default_nettype none

module prf
   import rr_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   // Writeback port
   input  logic  wb_we,
   input  preg_t wb_addr,
   input  data_t wb_data,
   // Read ports
   prf_rd_if.rf  rd
);

   data_t regs [PRF_NUM];

   // Output registers of the two read ports
   data_t rdata1_q;
   data_t rdata2_q;

   // Value a read of addr sees on this edge
   // A same-edge writeback wins over the array contents
   function automatic data_t read_val(input preg_t addr);
      if (wb_we && (wb_addr == addr))
      begin
         read_val = wb_data;
      end
      else
      begin
         read_val = regs[addr];
      end
   endfunction

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < PRF_NUM; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (wb_we)
      begin
         regs[wb_addr] <= wb_data;
      end
   end

   // Port 1 loads only on an enabled read
   always_ff @(posedge clk)
   begin
      if (rd.re1)
      begin
         rdata1_q <= read_val(rd.raddr1);
      end
   end

   // Port 2, same scheme
   always_ff @(posedge clk)
   begin
      if (rd.re2)
      begin
         rdata2_q <= read_val(rd.raddr2);
      end
   end

   assign rd.rdata1 = rdata1_q;
   assign rd.rdata2 = rdata2_q;

endmodule

`default_nettype wire

/* verilog/reg_read.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_read
   import rr_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    flush,
   // Issue side
   input  logic    a_valid,
   output logic    a_ready,
   input  opc_t    a_opc,
   input  fu_sel_t a_fu_sel,
   input  data_t   a_imm,
   input  pc_t     a_pc,
   input  preg_t   a_prd,
   input  logic    a_prd_we,
   input  rob_id_t a_rob_id,
   input  preg_t   a_prs1,
   input  logic    a_prs1_re,
   input  preg_t   a_prs2,
   input  logic    a_prs2_re,
   // PRF read requests
   prf_rd_if.stage rd,
   // Execute side
   output logic    ex_valid,
   input  logic    ex_ready,
   output opc_t    ex_opc,
   output fu_sel_t ex_fu_sel,
   output data_t   ex_imm,
   output pc_t     ex_pc,
   output preg_t   ex_prd,
   output logic    ex_prd_we,
   output rob_id_t ex_rob_id,
   output data_t   ex_operand1,
   output data_t   ex_operand2
);

   logic p_ce;

   // Which operands came from the PRF
   logic op1_en_q;
   logic op2_en_q;

   hds_buf u_buf (
      .clk     (clk),
      .rst_n   (rst_n),
      .flush   (flush),
      .a_valid (a_valid),
      .a_ready (a_ready),
      .b_valid (ex_valid),
      .b_ready (ex_ready),
      .p_ce    (p_ce)
   );

   // Side fields, loaded on acceptance
   always_ff @(posedge clk)
   begin
      if (p_ce)
      begin
         ex_opc    <= a_opc;
         ex_fu_sel <= a_fu_sel;
         ex_imm    <= a_imm;
         ex_pc     <= a_pc;
         ex_prd    <= a_prd;
         ex_prd_we <= a_prd_we;
         ex_rob_id <= a_rob_id;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         op1_en_q <= 1'b0;
         op2_en_q <= 1'b0;
      end
      else if (p_ce)
      begin
         op1_en_q <= a_prs1_re;
         op2_en_q <= a_prs2_re;
      end
   end

   // The PRF output registers act as this stage's operand registers
   assign rd.re1    = p_ce & a_prs1_re;
   assign rd.re2    = p_ce & a_prs2_re;
   assign rd.raddr1 = a_prs1;
   assign rd.raddr2 = a_prs2;

   assign ex_operand1 = op1_en_q ? rd.rdata1 : '0;   // Zero when not read
   assign ex_operand2 = op2_en_q ? rd.rdata2 : '0;

endmodule

`default_nettype wire

/* verilog/rr_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rr_top
   import rr_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    flush,
   // Issue side
   input  logic    a_valid,
   output logic    a_ready,
   input  opc_t    a_opc,
   input  fu_sel_t a_fu_sel,
   input  data_t   a_imm,
   input  pc_t     a_pc,
   input  preg_t   a_prd,
   input  logic    a_prd_we,
   input  rob_id_t a_rob_id,
   input  preg_t   a_prs1,
   input  logic    a_prs1_re,
   input  preg_t   a_prs2,
   input  logic    a_prs2_re,
   // Execute side
   output logic    ex_valid,
   input  logic    ex_ready,
   output opc_t    ex_opc,
   output fu_sel_t ex_fu_sel,
   output data_t   ex_imm,
   output pc_t     ex_pc,
   output preg_t   ex_prd,
   output logic    ex_prd_we,
   output rob_id_t ex_rob_id,
   output data_t   ex_operand1,
   output data_t   ex_operand2,
   // Writeback
   input  logic    wb_we,
   input  preg_t   wb_addr,
   input  data_t   wb_data
);

   prf_rd_if u_rd_if ();

   reg_read u_reg_read (
      .clk         (clk),
      .rst_n       (rst_n),
      .flush       (flush),
      .a_valid     (a_valid),
      .a_ready     (a_ready),
      .a_opc       (a_opc),
      .a_fu_sel    (a_fu_sel),
      .a_imm       (a_imm),
      .a_pc        (a_pc),
      .a_prd       (a_prd),
      .a_prd_we    (a_prd_we),
      .a_rob_id    (a_rob_id),
      .a_prs1      (a_prs1),
      .a_prs1_re   (a_prs1_re),
      .a_prs2      (a_prs2),
      .a_prs2_re   (a_prs2_re),
      .rd          (u_rd_if.stage),
      .ex_valid    (ex_valid),
      .ex_ready    (ex_ready),
      .ex_opc      (ex_opc),
      .ex_fu_sel   (ex_fu_sel),
      .ex_imm      (ex_imm),
      .ex_pc       (ex_pc),
      .ex_prd      (ex_prd),
      .ex_prd_we   (ex_prd_we),
      .ex_rob_id   (ex_rob_id),
      .ex_operand1 (ex_operand1),
      .ex_operand2 (ex_operand2)
   );

   // Writeback comes straight from outside
   prf u_prf (
      .clk     (clk),
      .rst_n   (rst_n),
      .wb_we   (wb_we),
      .wb_addr (wb_addr),
      .wb_data (wb_data),
      .rd      (u_rd_if.rf)
   );

endmodule

`default_nettype wire

/* verification/rr_checker.sv */
`timescale 1ns/1ps
`default_nettype none

// Protocol properties of the register-read stage
module rr_checker
   import rr_pkg::*;
(
   input logic clk,
   input logic rst_n,
   input logic flush,
   input logic a_valid,
   input logic a_ready,
   input logic ex_valid,
   input logic ex_ready,
   input logic re1,
   input logic re2,
   // Every ex_ field and both operands, concatenated
   input logic [OPC_W+FU_W+3*DW+PC_W+PRF_AW+ROB_AW:0] ex_fields
);

   // Held micro-op does not move under back-pressure
   a_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (ex_valid && !ex_ready && !flush) |=> (ex_valid && $stable(ex_fields)))
      else $error("execute side changed while stalled");

   a_re_gated: assert property (@(posedge clk) disable iff (!rst_n)
      (re1 || re2) |-> (a_ready && a_valid))
      else $error("PRF read without an accepting handshake");

   a_reset: assert property (@(posedge clk) $rose(rst_n) |-> !ex_valid)
      else $error("ex_valid high right after reset");

   a_ready_empty: assert property (@(posedge clk) disable iff (!rst_n)
      (!ex_valid && !flush) |-> a_ready)
      else $error("a_ready low with an empty stage");   // Empty stage always takes

endmodule

bind rr_top rr_checker u_checker (
   .clk       (clk),
   .rst_n     (rst_n),
   .flush     (flush),
   .a_valid   (a_valid),
   .a_ready   (a_ready),
   .ex_valid  (ex_valid),
   .ex_ready  (ex_ready),
   .re1       (u_rd_if.re1),
   .re2       (u_rd_if.re2),
   .ex_fields ({ex_opc, ex_fu_sel, ex_imm, ex_pc, ex_prd, ex_prd_we, ex_rob_id,
                ex_operand1, ex_operand2})
);

`default_nettype wire

/* verification/tb_rr_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rr_top
   import rr_pkg::*;
();

   localparam int TMO = 50;   // Cycles allowed per wait

   typedef struct packed {
      opc_t    opc;
      fu_sel_t fu_sel;
      data_t   imm;
      pc_t     pc;
      preg_t   prd;
      logic    prd_we;
      rob_id_t rob_id;
      data_t   op1;
      data_t   op2;
   } uop_t;

   logic    clk, rst_n, flush, a_valid, a_ready, a_prd_we, a_prs1_re, a_prs2_re;
   logic    ex_valid, ex_ready, ex_prd_we, wb_we;
   opc_t    a_opc, ex_opc;
   fu_sel_t a_fu_sel, ex_fu_sel;
   data_t   a_imm, ex_imm, ex_operand1, ex_operand2, wb_data;
   pc_t     a_pc, ex_pc;
   preg_t   a_prd, a_prs1, a_prs2, ex_prd, wb_addr;
   rob_id_t a_rob_id, ex_rob_id;

   data_t       ref_regs [PRF_NUM];   // Mirror of every writeback
   uop_t        exp_q [$];
   uop_t        head;
   int          n_fail, n_other, n_xfer;
   logic [31:0] lfsr = 32'h5a46;

   rr_top u_dut (.*);

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Fibonacci step with taps 32 22 2 1
   function automatic logic next_bit();
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      return lfsr[0];
   endfunction

   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v = {v[62:0], next_bit()};
      end
      return v;
   endfunction

   task automatic report(input string name, input data_t got, input data_t exp);
      $display("[FAIL] t=%0t %s got 'h%0h expected 'h%0h", $time, name, got, exp);
      n_fail++;
   endtask

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp) report(name, got, exp);
   endtask
   task automatic check_pc(input string name, input pc_t got, input pc_t exp);
      if (got !== exp) report(name, data_t'(got), data_t'(exp));
   endtask
   task automatic check_preg(input string name, input preg_t got, input preg_t exp);
      if (got !== exp) report(name, data_t'(got), data_t'(exp));
   endtask
   task automatic check_rob(input string name, input rob_id_t got, input rob_id_t exp);
      if (got !== exp) report(name, data_t'(got), data_t'(exp));
   endtask
   task automatic check_opc(input string name, input opc_t got, input opc_t exp);
      if (got !== exp) report(name, data_t'(got), data_t'(exp));
   endtask
   task automatic check_fu(input string name, input fu_sel_t got, input fu_sel_t exp);
      if (got !== exp) report(name, data_t'(got), data_t'(exp));
   endtask
   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) report(name, data_t'(got), data_t'(exp));
   endtask

   task automatic complain(input string what);
      $display("[%0t] Error: %s", $time, what);
      n_other++;
   endtask

   // Operand rule where a same-edge write wins
   function automatic data_t operand(input logic re, input preg_t idx);
      if (!re)
      begin
         return '0;
      end
      if (wb_we && (wb_addr == idx))
      begin
         return wb_data;
      end
      return ref_regs[idx];
   endfunction

   task automatic compare_uop(input uop_t e);
      check_opc("ex_opc", ex_opc, e.opc);
      check_fu("ex_fu_sel", ex_fu_sel, e.fu_sel);
      check_data("ex_imm", ex_imm, e.imm);
      check_pc("ex_pc", ex_pc, e.pc);
      check_preg("ex_prd", ex_prd, e.prd);
      check_bit("ex_prd_we", ex_prd_we, e.prd_we);
      check_rob("ex_rob_id", ex_rob_id, e.rob_id);
      check_data("ex_operand1", ex_operand1, e.op1);
      check_data("ex_operand2", ex_operand2, e.op2);
      n_xfer++;
   endtask

   // Looks ahead to the coming rising edge with all inputs settled
   always @(negedge clk)
   begin
      if (rst_n)
      begin
         if (ex_valid && (flush || ex_ready))
         begin
            if (exp_q.size() == 0)
            begin
               complain("execute side presented a micro-op that was never issued");
            end
            else
            begin
               head = exp_q.pop_front();   // Dropped without a check on flush
               if (!flush) compare_uop(head);
            end
         end
         if (a_valid && a_ready)
         begin
            exp_q.push_back(uop_t'{a_opc, a_fu_sel, a_imm, a_pc, a_prd, a_prd_we, a_rob_id,
                                   operand(a_prs1_re, a_prs1), operand(a_prs2_re, a_prs2)});
         end
         if (wb_we)
         begin
            ref_regs[wb_addr] = wb_data;
         end
      end
   end

   task automatic set_uop(input preg_t s1, input logic r1, input preg_t s2, input logic r2);
      a_opc     = opc_t'(rand_bits(OPC_W));
      a_fu_sel  = fu_sel_t'(1 << (rand_bits(3) % 64'd5));   // One-hot
      a_imm     = rand_bits(DW);
      a_pc      = pc_t'(rand_bits(PC_W));
      a_prd     = preg_t'(rand_bits(PRF_AW));
      a_prd_we  = logic'(rand_bits(1));
      a_rob_id  = rob_id_t'(rand_bits(ROB_AW));
      a_prs1    = s1;
      a_prs1_re = r1;
      a_prs2    = s2;
      a_prs2_re = r2;
   endtask

   // Offer one micro-op until it is taken
   task automatic issue(input preg_t s1, input logic r1, input preg_t s2, input logic r2);
      int n;
      n = 0;
      set_uop(s1, r1, s2, r2);
      a_valid = 1'b1;
      @(negedge clk);
      while (!a_ready && n < TMO)
      begin
         @(negedge clk);
         n++;
      end
      if (!a_ready) complain("issued micro-op was never accepted");
      @(posedge clk);
      #2;
      a_valid = 1'b0;
      check_bit("ex_valid", ex_valid, 1'b1);   // One cycle after acceptance
   endtask

   task automatic write_reg(input preg_t addr, input data_t data);
      wb_we   = 1'b1;
      wb_addr = addr;
      wb_data = data;
      @(posedge clk);
      #2;
      wb_we = 1'b0;
   endtask

   task automatic drain();
      int n;
      n = 0;
      ex_ready = 1'b1;
      while (exp_q.size() != 0 && n < TMO)
      begin
         @(negedge clk);
         #1;
         n++;
      end
      if (exp_q.size() != 0) complain("expected micro-ops never reached the execute side");
      @(posedge clk);
      #2;
   endtask

   task automatic after_reset();
      repeat (3)
      begin
         check_bit("ex_valid", ex_valid, 1'b0);
         check_bit("a_ready", a_ready, 1'b1);
         @(posedge clk);
         #2;
      end
   endtask

   task automatic field_passthrough();
      for (int i = 1; i <= 4; i++)
      begin
         write_reg(preg_t'(i), rand_bits(DW));
      end
      ex_ready = 1'b1;
      for (int k = 0; k < 4; k++)
      begin
         issue(preg_t'(k + 1), k[0], preg_t'(4 - k), k[1]);   // All read-enable pairs
      end
      drain();
   endtask

   task automatic held_under_stall();
      data_t held;
      pc_t   held_pc;
      ex_ready = 1'b0;
      write_reg(6'd9, rand_bits(DW));
      issue(6'd9, 1'b1, 6'd10, 1'b0);
      held    = ex_operand1;
      held_pc = ex_pc;
      write_reg(6'd9, rand_bits(DW));   // Source changes during the stall
      repeat (3)
      begin
         check_data("ex_operand1", ex_operand1, held);
         check_pc("ex_pc", ex_pc, held_pc);
         check_bit("a_ready", a_ready, 1'b0);
         @(posedge clk);
         #2;
      end
      fork
         issue(6'd9, 1'b1, 6'd9, 1'b1);
         begin
            repeat (2) @(posedge clk);
            #2;
            ex_ready = 1'b1;
         end
      join
      drain();
   endtask

   task automatic same_edge_bypass();
      data_t new_val;
      ex_ready = 1'b1;
      write_reg(6'd12, rand_bits(DW));
      new_val = rand_bits(DW);
      fork
         write_reg(6'd12, new_val);
         issue(6'd12, 1'b1, 6'd12, 1'b1);
      join
      check_data("ex_operand1", ex_operand1, new_val);
      drain();
   endtask

   task automatic flush_held_uop();
      ex_ready = 1'b0;
      issue(6'd3, 1'b1, 6'd4, 1'b1);
      flush = 1'b1;
      @(posedge clk);
      #2;
      flush = 1'b0;
      check_bit("ex_valid", ex_valid, 1'b0);
      if (exp_q.size() != 0) complain("flushed micro-op still expected");
      ex_ready = 1'b1;
      issue(6'd4, 1'b1, 6'd3, 1'b0);
      drain();
   endtask

   task automatic random_stream();
      preg_t s1, s2;
      logic  r1, r2;
      for (int c = 0; c < 200; c++)
      begin
         a_valid  = logic'(rand_bits(1));
         ex_ready = rand_bits(2) != '0;
         wb_we    = logic'(rand_bits(1));
         wb_addr  = preg_t'(rand_bits(4));   // Low registers only for more hazards
         wb_data  = rand_bits(DW);
         s1       = preg_t'(rand_bits(4));
         r1       = logic'(rand_bits(1));
         s2       = preg_t'(rand_bits(4));
         r2       = logic'(rand_bits(1));
         set_uop(s1, r1, s2, r2);
         @(posedge clk);
         #2;
      end
      a_valid = 1'b0;
      wb_we   = 1'b0;
      drain();
   endtask

   initial
   begin
      rst_n     = 1'b0;
      flush     = 1'b0;
      a_valid   = 1'b0;
      ex_ready  = 1'b0;
      wb_we     = 1'b0;
      wb_addr   = '0;
      wb_data   = '0;
      set_uop('0, 1'b0, '0, 1'b0);
      n_fail    = 0;
      n_other   = 0;
      n_xfer    = 0;
      for (int i = 0; i < PRF_NUM; i++)
      begin
         ref_regs[i] = '0;
      end
      repeat (2) @(posedge clk);
      #2;
      rst_n = 1'b1;
      after_reset();
      field_passthrough();
      held_under_stall();
      same_edge_bypass();
      flush_held_uop();
      random_stream();
      $display("Transfers %0d, value errors %0d, other errors %0d", n_xfer, n_fail, n_other);
      if (n_fail == 0 && n_other == 0)
      begin
         $display("sim passed");
      end
      else
      begin
         $display("sim failed");
      end
      $finish;
   end

   // Last resort against a hang
   initial
   begin
      #100000;
      $display("Error: simulation ran past its time limit");
      $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
verilog/rr_pkg.sv
verilog/prf_rd_if.sv
verilog/hds_buf.sv
verilog/prf.sv
verilog/reg_read.sv
verilog/rr_top.sv
verification/rr_checker.sv
verification/tb_rr_top.sv

/* Makefile */
# Verilator build and run for the register-read stage

TOP = tb_rr_top

all: run

obj_dir/V$(TOP): flist.f verilog/*.sv verification/*.sv
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "sim failed" sim.log; then exit 1; fi
	@grep -q "sim passed" sim.log

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module rr_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
